/* logic/sld_macros.svh */
/*
 * slide unit constants, widths and counts shared by the package and the RTL
 */

`ifndef SLD_MACROS_SVH
`define SLD_MACROS_SVH

// register and chunk geometry, LMUL 1 only
`define SLD_VREG_W      128
`define SLD_OP_W        32
`define SLD_CHUNKS      4
`define SLD_VREG_BYTES  16
`define SLD_OP_BYTES    4

// operation fields
`define SLD_OFS_W       8   // scalar element offset
`define SLD_VL_W        5   // vl holds 0 to 16
`define SLD_ID_W        3   // instruction id

`endif

/* logic/sld_pkg.sv */
/*
 * slide unit types: operation mode, element width and per-chunk pipeline state
 */

`include "sld_macros.svh"

package sld_pkg;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_dir_e;

    typedef struct packed {
        sld_dir_e dir;
        logic     slide1;   // scalar insert variant
        logic     masked;   // v0 gates the write
    } sld_mode_t;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } sld_eew_e;

    // travels with every chunk down the pipeline
    typedef struct packed {
        logic [$clog2(`SLD_CHUNKS)-1:0] idx;
        logic                           first;
        logic                           last;
        sld_mode_t                      mode;
        sld_eew_e                       eew;
        logic [`SLD_VL_W-1:0]           vl;
        logic [`SLD_ID_W-1:0]           id;
        logic signed [8:0]              byte_ofs;   // +up / -down, saturated to 16 bytes
        logic [4:0]                     vd;
    } sld_chunk_t;

endpackage

/* logic/sld_sequencer.sv */
/*
 * slide sequencer: accepts one operation, turns the element offset into a
 * byte offset, fetches vs2 and then issues the register as four chunks
 */

`include "sld_macros.svh"

module sld_sequencer (
    input  logic                   clk_i,
    input  logic                   async_rst_ni,
    input  logic                   op_valid_i,
    input  logic [`SLD_ID_W-1:0]   id_i,
    input  sld_pkg::sld_mode_t     mode_i,
    input  sld_pkg::sld_eew_e      eew_i,
    input  logic [`SLD_VL_W-1:0]   vl_i,
    input  logic [`SLD_OFS_W-1:0]  offset_i,
    input  logic [4:0]             vs2_addr_i,
    input  logic [4:0]             vd_addr_i,
    output logic                   busy_o,
    output logic [4:0]             vreg_rd_addr_o,
    output logic                   fetch_o,
    output logic                   chunk_valid_o,
    output sld_pkg::sld_chunk_t    chunk_o
);

    localparam logic [2:0] LAST_STEP = 3'd7;   // write cycle, busy drops after it

    logic                    busy_q;
    logic [2:0]              step_q;
    sld_pkg::sld_chunk_t     op_q;
    logic [4:0]              vs2_addr_q;

    logic [`SLD_OFS_W-1:0]   ofs_elems;
    logic [`SLD_OFS_W+1:0]   ofs_bytes;
    logic [8:0]              ofs_sat;
    logic signed [8:0]       byte_ofs;

    ////////////////////
    // offset conversion

    always_comb begin
        ofs_elems = mode_i.slide1 ? {{(`SLD_OFS_W-1){1'b0}}, 1'b1} : offset_i;
        case (eew_i)
            sld_pkg::EEW_16: ofs_bytes = {1'b0, ofs_elems, 1'b0};
            sld_pkg::EEW_32: ofs_bytes = {ofs_elems, 2'b00};
            default:         ofs_bytes = {2'b00, ofs_elems};
        endcase
        if (ofs_bytes > `SLD_VREG_BYTES) begin
            ofs_sat = 9'(`SLD_VREG_BYTES);   // anything past the register acts the same
        end else begin
            ofs_sat = ofs_bytes[8:0];
        end
        byte_ofs = (mode_i.dir == sld_pkg::SLD_DOWN) ? -ofs_sat : ofs_sat;
    end

    ////////////////////
    // step counter

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            step_q <= '0;
        end else if (op_valid_i && !busy_q) begin
            busy_q <= 1'b1;
            step_q <= '0;
        end else if (busy_q) begin
            step_q <= step_q + 3'd1;
            if (step_q == LAST_STEP) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_valid_i && !busy_q) begin
            op_q.idx      <= '0;
            op_q.first    <= 1'b0;
            op_q.last     <= 1'b0;
            op_q.mode     <= mode_i;
            op_q.eew      <= eew_i;
            op_q.vl       <= vl_i;
            op_q.id       <= id_i;
            op_q.byte_ofs <= byte_ofs;
            op_q.vd       <= vd_addr_i;
            vs2_addr_q    <= vs2_addr_i;
        end
    end

    assign busy_o         = busy_q;
    assign vreg_rd_addr_o = vs2_addr_q;
    assign fetch_o        = busy_q && (step_q == 3'd0);
    assign chunk_valid_o  = busy_q && (step_q != 3'd0) && (step_q <= 3'(`SLD_CHUNKS));

    // steps 1 to 4 carry chunks 0 to 3
    always_comb begin
        chunk_o       = op_q;
        chunk_o.idx   = 2'(step_q - 3'd1);
        chunk_o.first = (step_q == 3'd1);
        chunk_o.last  = (step_q == 3'(`SLD_CHUNKS));
    end

    assert property (@(posedge clk_i) disable iff (!async_rst_ni) op_valid_i |-> !busy_o)
        else $error("slide operation issued while busy");

    // vs2 is captured before the first chunk, then exactly four chunks follow
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        fetch_o |-> !chunk_valid_o ##1 chunk_valid_o ##1 chunk_valid_o ##1 chunk_valid_o
            ##1 chunk_valid_o ##1 !chunk_valid_o)
        else $error("chunk sequence does not follow the vs2 fetch");

endmodule

/* logic/sld_operand_fetch.sv */
/*
 * operand fetch: holds vs2 and the scalar, picks the two source chunks that
 * a result chunk needs and fills invalid sources with the scalar for slide1
 */

`include "sld_macros.svh"

module sld_operand_fetch (
    input  logic                       clk_i,
    input  logic                       async_rst_ni,
    input  logic                       fetch_i,
    input  logic [`SLD_VREG_W-1:0]     vreg_rd_i,
    input  logic [`SLD_OP_W-1:0]       scalar_i,
    input  logic                       chunk_valid_i,
    input  sld_pkg::sld_chunk_t        chunk_i,
    output logic                       ex_valid_o,
    output sld_pkg::sld_chunk_t        ex_chunk_o,
    output logic [`SLD_OP_W-1:0]       op_high_o,
    output logic [`SLD_OP_W-1:0]       op_low_o,
    output logic                       high_valid_o,
    output logic                       low_valid_o
);

    logic [`SLD_VREG_W-1:0] vs2_q;
    logic [`SLD_VREG_W-1:0] vs2_eff;
    logic [`SLD_OP_W-1:0]   scalar_prev_q;   // scalar as seen in the strobe cycle
    logic [`SLD_OP_W-1:0]   scalar_rep_q;
    logic [6:0]             vl_bytes;
    logic signed [4:0]      chunk_shift;
    logic signed [4:0]      hi_idx;
    logic signed [4:0]      lo_idx;
    logic                   hi_in;
    logic                   lo_in;
    logic [`SLD_OP_W-1:0]   hi_data;
    logic [`SLD_OP_W-1:0]   lo_data;

    function automatic logic [`SLD_OP_W-1:0] rep_scalar(input logic [`SLD_OP_W-1:0] s,
                                                        input sld_pkg::sld_eew_e eew);
        case (eew)
            sld_pkg::EEW_8:  return {(`SLD_OP_W/8){s[7:0]}};
            sld_pkg::EEW_16: return {(`SLD_OP_W/16){s[15:0]}};
            default:         return s;
        endcase
    endfunction

    // fetch comes one cycle after the strobe, so keep the scalar one cycle
    always_ff @(posedge clk_i) begin
        scalar_prev_q <= scalar_i;
        if (fetch_i) begin
            vs2_q        <= vreg_rd_i;
            scalar_rep_q <= rep_scalar(scalar_prev_q, chunk_i.eew);   // op state already held
        end
    end

    // slide1down: source bytes at and above vl read as the scalar
    always_comb begin
        case (chunk_i.eew)
            sld_pkg::EEW_16: vl_bytes = {1'b0, chunk_i.vl, 1'b0};
            sld_pkg::EEW_32: vl_bytes = {chunk_i.vl, 2'b00};
            default:         vl_bytes = {2'b00, chunk_i.vl};
        endcase
        vs2_eff = vs2_q;
        for (int b = 0; b < `SLD_VREG_BYTES; b++) begin
            if (chunk_i.mode.slide1 && (chunk_i.mode.dir == sld_pkg::SLD_DOWN)
                && (7'(b) >= vl_bytes)) begin
                vs2_eff[b*8 +: 8] = scalar_rep_q[(b % `SLD_OP_BYTES)*8 +: 8];
            end
        end
    end

    ////////////////////
    // source chunk select

    assign chunk_shift = 5'($signed(chunk_i.byte_ofs) >>> 2);   // floor, in chunks
    assign hi_idx      = $signed({3'b000, chunk_i.idx}) - chunk_shift;
    assign lo_idx      = hi_idx - 5'sd1;
    assign hi_in       = (hi_idx[4:2] == 3'b000);   // 0..3
    assign lo_in       = (lo_idx[4:2] == 3'b000);
    assign hi_data     = hi_in ? vs2_eff[hi_idx[1:0]*`SLD_OP_W +: `SLD_OP_W] : scalar_rep_q;
    assign lo_data     = lo_in ? vs2_eff[lo_idx[1:0]*`SLD_OP_W +: `SLD_OP_W] : scalar_rep_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= chunk_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (chunk_valid_i) begin
            ex_chunk_o   <= chunk_i;
            op_high_o    <= hi_data;
            op_low_o     <= lo_data;
            high_valid_o <= hi_in || chunk_i.mode.slide1;   // scalar stands in
            low_valid_o  <= lo_in || chunk_i.mode.slide1;
        end
    end

endmodule

/* logic/sld_shifter.sv */
/*
 * byte funnel shift of one chunk across its low and high operand, with a
 * per-byte flag telling whether the byte came from a valid source
 */

`include "sld_macros.svh"

module sld_shifter (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,
    input  logic                        ex_valid_i,
    input  sld_pkg::sld_chunk_t         ex_chunk_i,
    input  logic [`SLD_OP_W-1:0]        op_high_i,
    input  logic [`SLD_OP_W-1:0]        op_low_i,
    input  logic                        high_valid_i,
    input  logic                        low_valid_i,
    output logic                        res_valid_o,
    output sld_pkg::sld_chunk_t         res_chunk_o,
    output logic [`SLD_OP_W-1:0]        res_data_o,
    output logic [`SLD_OP_BYTES-1:0]    res_src_mask_o
);

    logic [1:0]                shift;   // byte offset within the chunk
    logic [`SLD_OP_W-1:0]      shifted;
    logic [`SLD_OP_BYTES-1:0]  src_ok;

    assign shift = ex_chunk_i.byte_ofs[1:0];

    always_comb begin
        for (int i = 0; i < `SLD_OP_BYTES; i++) begin
            if (2'(i) < shift) begin
                shifted[i*8 +: 8] = op_low_i[(`SLD_OP_BYTES + i - int'(shift))*8 +: 8];
                src_ok[i]         = low_valid_i;
            end else begin
                shifted[i*8 +: 8] = op_high_i[(i - int'(shift))*8 +: 8];
                src_ok[i]         = high_valid_i;
            end
            if (!src_ok[i]) begin
                shifted[i*8 +: 8] = 8'h00;   // past the register reads as zero
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            res_chunk_o    <= ex_chunk_i;
            res_data_o     <= shifted;
            res_src_mask_o <= src_ok;
        end
    end

endmodule

/* logic/sld_result_pack.sv */
/*
 * result pack: builds the byte enables from vl, v0 and the prestart rule and
 * collects the four chunks into one vd write with its done strobe
 */

`include "sld_macros.svh"

module sld_result_pack (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,
    input  logic                          res_valid_i,
    input  sld_pkg::sld_chunk_t           res_chunk_i,
    input  logic [`SLD_OP_W-1:0]          res_data_i,
    input  logic [`SLD_OP_BYTES-1:0]      res_src_mask_i,
    input  logic [`SLD_VREG_W-1:0]        vreg_mask_i,
    output logic                          vreg_wr_en_o,
    output logic [4:0]                    vreg_wr_addr_o,
    output logic [`SLD_VREG_W-1:0]        vreg_wr_o,
    output logic [`SLD_VREG_BYTES-1:0]    vreg_wr_mask_o,
    output logic                          done_o,
    output logic [`SLD_ID_W-1:0]          done_id_o
);

    localparam int unsigned POS_W = $clog2(`SLD_VREG_BYTES);
    localparam int unsigned SUB_W = $clog2(`SLD_OP_BYTES);

    logic [6:0]               vl_bytes;
    logic [POS_W-1:0]         byte_pos [`SLD_OP_BYTES];
    logic [POS_W-1:0]         elem_idx [`SLD_OP_BYTES];
    logic [`SLD_OP_BYTES-1:0] chunk_be;
    logic                     up_plain;   // slide-up without scalar insert

    assign up_plain = (res_chunk_i.mode.dir == sld_pkg::SLD_UP) && !res_chunk_i.mode.slide1;

    ////////////////////
    // byte enables

    // the vl test also keeps slide1down from writing past element vl-1
    always_comb begin
        case (res_chunk_i.eew)
            sld_pkg::EEW_16: vl_bytes = {1'b0, res_chunk_i.vl, 1'b0};
            sld_pkg::EEW_32: vl_bytes = {res_chunk_i.vl, 2'b00};
            default:         vl_bytes = {2'b00, res_chunk_i.vl};
        endcase
        for (int i = 0; i < `SLD_OP_BYTES; i++) begin
            byte_pos[i] = {res_chunk_i.idx, SUB_W'(i)};
            case (res_chunk_i.eew)
                sld_pkg::EEW_16: elem_idx[i] = byte_pos[i] >> 1;
                sld_pkg::EEW_32: elem_idx[i] = byte_pos[i] >> 2;
                default:         elem_idx[i] = byte_pos[i];
            endcase
            chunk_be[i] = (7'(byte_pos[i]) < vl_bytes);
            if (res_chunk_i.mode.masked && !vreg_mask_i[elem_idx[i]]) begin
                chunk_be[i] = 1'b0;   // v0 bit clear
            end
            if (up_plain && !res_src_mask_i[i]) begin
                chunk_be[i] = 1'b0;   // prestart element keeps old vd
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vreg_wr_en_o <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            vreg_wr_en_o <= res_valid_i && (res_chunk_i.idx == 2'(`SLD_CHUNKS-1));
            done_o       <= res_valid_i && res_chunk_i.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (res_valid_i) begin
            vreg_wr_o[res_chunk_i.idx*`SLD_OP_W +: `SLD_OP_W]              <= res_data_i;
            vreg_wr_mask_o[res_chunk_i.idx*`SLD_OP_BYTES +: `SLD_OP_BYTES] <= chunk_be;
        end
        if (res_valid_i && res_chunk_i.first) begin
            vreg_wr_addr_o <= res_chunk_i.vd;   // operation fields from the first chunk
            done_id_o      <= res_chunk_i.id;
        end
    end

    // final slot filled and last flag from the sequencer must agree
    assert property (@(posedge clk_i) disable iff (!async_rst_ni) vreg_wr_en_o == done_o)
        else $error("vd write and done strobe out of step");

endmodule

/* logic/sld_unit_top.sv */
/*
 * vector slide unit top: sequencer, operand fetch, shifter and result pack
 */

`include "sld_macros.svh"

module sld_unit_top (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         op_valid_i,
    input  logic [`SLD_ID_W-1:0]         id_i,
    input  sld_pkg::sld_mode_t           mode_i,
    input  sld_pkg::sld_eew_e            eew_i,
    input  logic [`SLD_VL_W-1:0]         vl_i,
    input  logic [`SLD_OFS_W-1:0]        offset_i,
    input  logic [`SLD_OP_W-1:0]         scalar_i,
    input  logic [4:0]                   vs2_addr_i,
    input  logic [4:0]                   vd_addr_i,
    input  logic [`SLD_VREG_W-1:0]       vreg_rd_i,
    input  logic [`SLD_VREG_W-1:0]       vreg_mask_i,
    output logic                         busy_o,
    output logic [4:0]                   vreg_rd_addr_o,
    output logic                         vreg_wr_en_o,
    output logic [4:0]                   vreg_wr_addr_o,
    output logic [`SLD_VREG_W-1:0]       vreg_wr_o,
    output logic [`SLD_VREG_BYTES-1:0]   vreg_wr_mask_o,
    output logic                         done_o,
    output logic [`SLD_ID_W-1:0]         done_id_o
);

    logic                      fetch, chunk_valid, ex_valid, res_valid;
    logic                      high_valid, low_valid;
    sld_pkg::sld_chunk_t       chunk, ex_chunk, res_chunk;
    logic [`SLD_OP_W-1:0]      op_high, op_low, res_data;
    logic [`SLD_OP_BYTES-1:0]  res_src_mask;

    sld_sequencer u_seq (
        .clk_i, .async_rst_ni, .op_valid_i, .id_i, .mode_i, .eew_i, .vl_i, .offset_i,
        .vs2_addr_i, .vd_addr_i, .busy_o, .vreg_rd_addr_o,
        .fetch_o(fetch), .chunk_valid_o(chunk_valid), .chunk_o(chunk)
    );

    sld_operand_fetch u_fetch (
        .clk_i, .async_rst_ni, .fetch_i(fetch), .vreg_rd_i, .scalar_i,
        .chunk_valid_i(chunk_valid), .chunk_i(chunk),
        .ex_valid_o(ex_valid), .ex_chunk_o(ex_chunk), .op_high_o(op_high), .op_low_o(op_low),
        .high_valid_o(high_valid), .low_valid_o(low_valid)
    );

    sld_shifter u_shift (
        .clk_i, .async_rst_ni, .ex_valid_i(ex_valid), .ex_chunk_i(ex_chunk),
        .op_high_i(op_high), .op_low_i(op_low), .high_valid_i(high_valid),
        .low_valid_i(low_valid), .res_valid_o(res_valid), .res_chunk_o(res_chunk),
        .res_data_o(res_data), .res_src_mask_o(res_src_mask)
    );

    sld_result_pack u_pack (
        .clk_i, .async_rst_ni, .res_valid_i(res_valid), .res_chunk_i(res_chunk),
        .res_data_i(res_data), .res_src_mask_i(res_src_mask), .vreg_mask_i,
        .vreg_wr_en_o, .vreg_wr_addr_o, .vreg_wr_o, .vreg_wr_mask_o, .done_o, .done_id_o
    );

endmodule

/* verification/sld_unit_tb.sv */
/*
 * testbench for the vector slide unit: register file model, reference slide
 * model and directed tests over all element widths
 */

`include "sld_macros.svh"

module sld_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT    = 20;   // cycles per wait
    localparam int WR_LATENCY = 8;    // strobe edge to the write cycle

    logic                         clk_i;
    logic                         async_rst_ni;
    logic                         op_valid_i;
    logic [`SLD_ID_W-1:0]         id_i;
    sld_pkg::sld_mode_t           mode_i;
    sld_pkg::sld_eew_e            eew_i;
    logic [`SLD_VL_W-1:0]         vl_i;
    logic [`SLD_OFS_W-1:0]        offset_i;
    logic [`SLD_OP_W-1:0]         scalar_i;
    logic [4:0]                   vs2_addr_i;
    logic [4:0]                   vd_addr_i;
    logic [`SLD_VREG_W-1:0]       vreg_rd_i;
    logic [`SLD_VREG_W-1:0]       vreg_mask_i;
    logic                         busy_o;
    logic [4:0]                   vreg_rd_addr_o;
    logic                         vreg_wr_en_o;
    logic [4:0]                   vreg_wr_addr_o;
    logic [`SLD_VREG_W-1:0]       vreg_wr_o;
    logic [`SLD_VREG_BYTES-1:0]   vreg_wr_mask_o;
    logic                         done_o;
    logic [`SLD_ID_W-1:0]         done_id_o;

    logic [`SLD_VREG_W-1:0]       regs [32];   // register file model, v0 is regs[0]
    integer                       seed;
    logic [`SLD_ID_W-1:0]         next_id;

    sld_unit_top dut (.*);

    assign vreg_rd_i   = regs[vreg_rd_addr_o];   // read port answers in the same cycle
    assign vreg_mask_i = regs[0];

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "slide unit testbench stopped");
    endtask

    // drive and sample point, 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #10;
    endtask

    function automatic logic [`SLD_VREG_W-1:0] rand_vreg();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic int vlmax_of(input sld_pkg::sld_eew_e eew);
        return `SLD_VREG_BYTES >> int'(eew);
    endfunction

    function automatic sld_pkg::sld_mode_t mode_of(input sld_pkg::sld_dir_e dir,
                                                   input logic slide1, input logic masked);
        sld_pkg::sld_mode_t m;
        m.dir    = dir;
        m.slide1 = slide1;
        m.masked = masked;
        return m;
    endfunction

    ////////////////////
    // reference model

    function automatic void ref_slide(input logic [`SLD_VREG_W-1:0] old_vd,
                                      input logic [`SLD_VREG_W-1:0] vs2,
                                      input logic [`SLD_VREG_W-1:0] v0,
                                      input sld_pkg::sld_mode_t mode,
                                      input sld_pkg::sld_eew_e eew,
                                      input int vl,
                                      input int ofs,
                                      input logic [31:0] scalar,
                                      output logic [`SLD_VREG_W-1:0] vd_exp,
                                      output logic [`SLD_VREG_BYTES-1:0] be_exp);
        int          eb;
        int          vlmax;
        int          step;
        int          src;
        logic        en;
        logic [31:0] elem;
        vlmax  = vlmax_of(eew);
        eb     = `SLD_VREG_BYTES / vlmax;   // bytes per element
        step   = mode.slide1 ? 1 : ofs;
        vd_exp = old_vd;
        be_exp = '0;
        for (int i = 0; i < vlmax; i++) begin
            src = (mode.dir == sld_pkg::SLD_UP) ? i - step : i + step;
            en  = (i < vl) && (!mode.masked || v0[i]);
            if (mode.dir == sld_pkg::SLD_UP && !mode.slide1 && i < ofs) begin
                en = 1'b0;   // prestart element keeps old value
            end
            if (mode.slide1 && i == ((mode.dir == sld_pkg::SLD_UP) ? 0 : vl - 1)) begin
                elem = scalar;
            end else if (src >= 0 && src < vlmax) begin
                elem = 32'(vs2 >> (src * eb * 8));
            end else begin
                elem = '0;   // past the register
            end
            if (en) begin
                for (int b = 0; b < eb; b++) begin
                    vd_exp[(i * eb + b) * 8 +: 8] = elem[b * 8 +: 8];
                    be_exp[i * eb + b]            = 1'b1;
                end
            end
        end
    endfunction

    // issue one slide as soon as the unit is idle, then check its vd write
    task automatic run_slide(input sld_pkg::sld_mode_t mode, input sld_pkg::sld_eew_e eew,
                             input int vl, input int ofs, input logic [31:0] scalar,
                             input logic [4:0] vs2, input logic [4:0] vd);
        logic [`SLD_VREG_W-1:0]     vd_exp;
        logic [`SLD_VREG_BYTES-1:0] be_exp;
        logic [`SLD_ID_W-1:0]       id;
        int                         cycles;
        cycles = 0;
        while (busy_o) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_error("timeout: busy_o stayed high and the unit never became idle");
            end
        end
        ref_slide(regs[vd], regs[vs2], regs[0], mode, eew, vl, ofs, scalar, vd_exp, be_exp);
        id         = next_id;
        next_id    = next_id + 1'b1;
        op_valid_i = 1'b1;
        id_i       = id;
        mode_i     = mode;
        eew_i      = eew;
        vl_i       = `SLD_VL_W'(vl);
        offset_i   = `SLD_OFS_W'(ofs);
        scalar_i   = scalar;
        vs2_addr_i = vs2;
        vd_addr_i  = vd;
        next_cycle();
        op_valid_i = 1'b0;
        assert (busy_o)
            else stop_on_error($sformatf("Fail at %0d ns: busy_o low after the issue", $time));
        cycles     = 0;
        while (!done_o) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_error("timeout: done_o did not rise within 20 cycles of the issue");
            end
        end
        assert (cycles == WR_LATENCY - 1)
            else stop_on_error($sformatf("Fail at %0d ns: write %0d cycles after issue, expected %0d",
                                         $time, cycles + 1, WR_LATENCY));
        assert (busy_o)
            else stop_on_error($sformatf("Fail at %0d ns: busy_o low in the write cycle", $time));
        assert (vreg_wr_en_o)
            else stop_on_error($sformatf("Fail at %0d ns: done_o without vd write", $time));
        assert (vreg_wr_addr_o == vd)
            else stop_on_error($sformatf("Fail at %0d ns: vd addr %0d, expected %0d",
                                         $time, vreg_wr_addr_o, vd));
        assert (done_id_o == id)
            else stop_on_error($sformatf("Fail at %0d ns: done id %0d, expected %0d",
                                         $time, done_id_o, id));
        assert (vreg_wr_mask_o == be_exp)
            else stop_on_error($sformatf("Fail at %0d ns: byte enables %h, expected %h",
                                         $time, vreg_wr_mask_o, be_exp));
        for (int b = 0; b < `SLD_VREG_BYTES; b++) begin
            if (vreg_wr_mask_o[b]) begin
                regs[vd][b * 8 +: 8] = vreg_wr_o[b * 8 +: 8];
            end
        end
        assert (regs[vd] == vd_exp)
            else stop_on_error($sformatf("Fail at %0d ns: vd %h, expected %h",
                                         $time, regs[vd], vd_exp));
    endtask

    ////////////////////
    // directed tests

    task automatic test_slide_up();
        int                ofs_list [4] = '{0, 1, 3, 20};
        sld_pkg::sld_eew_e eew;
        for (int e = 0; e < 3; e++) begin
            eew = sld_pkg::sld_eew_e'(e);
            foreach (ofs_list[k]) begin
                regs[2] = rand_vreg();   // fresh old vd
                run_slide(mode_of(sld_pkg::SLD_UP, 1'b0, 1'b0), eew, vlmax_of(eew),
                          ofs_list[k], '0, 5'd1, 5'd2);
            end
        end
    endtask

    task automatic test_slide_down();
        int                ofs_list [3] = '{0, 2, 5};
        sld_pkg::sld_eew_e eew;
        for (int e = 0; e < 3; e++) begin
            eew = sld_pkg::sld_eew_e'(e);
            foreach (ofs_list[k]) begin
                regs[3] = rand_vreg();
                run_slide(mode_of(sld_pkg::SLD_DOWN, 1'b0, 1'b0), eew, vlmax_of(eew),
                          ofs_list[k], '0, 5'd3, 5'd4);
            end
        end
    endtask

    // full vl and a random vl below the maximum, both directions
    task automatic test_slide1();
        sld_pkg::sld_eew_e eew;
        int                vl;
        for (int e = 0; e < 3; e++) begin
            eew = sld_pkg::sld_eew_e'(e);
            for (int k = 0; k < 4; k++) begin
                vl = (k < 2) ? vlmax_of(eew)
                             : 1 + ($unsigned($random(seed)) % (vlmax_of(eew) - 1));
                regs[5] = rand_vreg();
                run_slide(mode_of(sld_pkg::sld_dir_e'(k % 2), 1'b1, 1'b0), eew, vl, 0,
                          $random(seed), 5'd7, 5'd5);
            end
        end
    endtask

    task automatic test_masked();
        sld_pkg::sld_eew_e eew;
        int                vl;
        for (int e = 0; e < 3; e++) begin
            eew = sld_pkg::sld_eew_e'(e);
            for (int k = 0; k < 4; k++) begin
                regs[0] = rand_vreg();
                vl = (k == 3) ? 0 : $unsigned($random(seed)) % (vlmax_of(eew) + 1);
                run_slide(mode_of(sld_pkg::sld_dir_e'(k % 2), k == 2, 1'b1), eew, vl, k + 1,
                          $random(seed), 5'd9, 5'd6);
            end
        end
    endtask

    task automatic test_back_to_back();
        sld_pkg::sld_eew_e eew;
        for (int k = 0; k < 6; k++) begin
            eew = sld_pkg::sld_eew_e'(k % 3);
            run_slide(mode_of(sld_pkg::sld_dir_e'(k % 2), k >= 3, 1'b0), eew, vlmax_of(eew),
                      k, $random(seed), 5'(16 + k), 5'(8 + k));
        end
    endtask

    initial begin
        seed         = 32'hc6b1;
        async_rst_ni = 1'b0;
        op_valid_i   = 1'b0;
        id_i         = '0;
        mode_i       = '0;
        eew_i        = sld_pkg::EEW_8;
        vl_i         = '0;
        offset_i     = '0;
        scalar_i     = '0;
        vs2_addr_i   = '0;
        vd_addr_i    = '0;
        next_id      = '0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = rand_vreg();
        end
        repeat (3) @(posedge clk_i);
        #10;
        async_rst_ni = 1'b1;
        next_cycle();
        test_slide_up();
        test_slide_down();
        test_slide1();
        test_masked();
        test_back_to_back();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/sld_pkg.sv
logic/sld_sequencer.sv
logic/sld_operand_fetch.sv
logic/sld_shifter.sv
logic/sld_result_pack.sv
logic/sld_unit_top.sv
verification/sld_unit_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = sld_unit_tb
FILELIST  = all.f

.PHONY: sim clean

# the run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
